//--- bht.sv
// branch history table
`default_nettype none

`include "fetch_settings.svh"

module bht
  import fetch_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // lookup from pc_gen
  input  bht_idx_t rd_idx_i,
  output logic     rd_valid_o,
  output logic     rd_taken_o,
  // training from the backend
  input  logic     upd_valid_i,
  input  bht_idx_t upd_idx_i,
  input  logic     upd_taken_i
);

  localparam int unsigned Entries = `FETCH_BHT_ENTRIES;

  logic       valid_q [Entries];
  logic [1:0] cnt_q   [Entries];

  // combinational read, msb of the counter is the prediction
  assign rd_valid_o = valid_q[rd_idx_i];
  assign rd_taken_o = cnt_q[rd_idx_i][1];

  // --------------------
  // counter update
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Entries; i++) begin
        valid_q[i] <= 1'b0;
        cnt_q[i]   <= 2'd0;
      end
    end else if (upd_valid_i) begin
      if (!valid_q[upd_idx_i]) begin
        // first sighting starts weakly in the resolved direction
        valid_q[upd_idx_i] <= 1'b1;
        cnt_q[upd_idx_i]   <= upd_taken_i ? 2'd2 : 2'd1;
      end else if (upd_taken_i && (cnt_q[upd_idx_i] != 2'd3)) begin
        cnt_q[upd_idx_i] <= cnt_q[upd_idx_i] + 2'd1;
      end else if (!upd_taken_i && (cnt_q[upd_idx_i] != 2'd0)) begin
        cnt_q[upd_idx_i] <= cnt_q[upd_idx_i] - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- fetch_frontend.sv
// instruction fetch frontend
`default_nettype none

module fetch_frontend
  import fetch_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  // instruction memory port
  output logic   imem_req_o,
  output addr_t  imem_addr_o,
  input  logic   imem_gnt_i,
  input  logic   imem_rvalid_i,
  input  instr_t imem_rdata_i,
  // backend port
  input  logic   resolve_valid_i,
  input  addr_t  resolve_pc_i,
  input  logic   resolve_branch_i,
  input  logic   resolve_taken_i,
  input  logic   resolve_mispredict_i,
  input  addr_t  resolve_target_i,
  input  logic   trap_i,
  input  addr_t  trap_vector_i,
  // decode port
  output logic   fetch_valid_o,
  input  logic   fetch_ready_i,
  output addr_t  fetch_pc_o,
  output instr_t fetch_instr_o,
  output logic   fetch_pred_taken_o,
  output addr_t  fetch_pred_target_o
);

  addr_t    scan_pc;
  instr_t   scan_instr;
  cf_e      scan_cf;
  addr_t    scan_imm;
  logic     scan_call;
  bht_idx_t bht_idx;
  logic     bht_valid;
  logic     bht_taken;
  logic     bht_upd_valid;
  bht_idx_t bht_upd_idx;
  logic     ras_push;
  logic     ras_pop;
  addr_t    ras_data;
  addr_t    ras_top;
  logic     ras_valid;
  logic     q_push;
  logic     q_taken;
  addr_t    q_target;
  logic     q_flush;
  q_cnt_t   q_free;

  // only resolved conditional branches train the history
  assign bht_upd_valid = resolve_valid_i && resolve_branch_i;
  assign bht_upd_idx   = bht_index(resolve_pc_i);

  pc_gen u_pc_gen (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .imem_req_o           (imem_req_o),
    .imem_addr_o          (imem_addr_o),
    .imem_gnt_i           (imem_gnt_i),
    .imem_rvalid_i        (imem_rvalid_i),
    .imem_rdata_i         (imem_rdata_i),
    .trap_i               (trap_i),
    .trap_vector_i        (trap_vector_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_mispredict_i (resolve_mispredict_i),
    .resolve_target_i     (resolve_target_i),
    .scan_pc_o            (scan_pc),
    .scan_instr_o         (scan_instr),
    .scan_cf_i            (scan_cf),
    .scan_imm_i           (scan_imm),
    .scan_call_i          (scan_call),
    .bht_idx_o            (bht_idx),
    .bht_valid_i          (bht_valid),
    .bht_taken_i          (bht_taken),
    .ras_push_o           (ras_push),
    .ras_pop_o            (ras_pop),
    .ras_data_o           (ras_data),
    .ras_top_i            (ras_top),
    .ras_valid_i          (ras_valid),
    .q_push_o             (q_push),
    .q_taken_o            (q_taken),
    .q_target_o           (q_target),
    .q_flush_o            (q_flush),
    .q_free_i             (q_free)
  );

  instr_scan u_scan (
    .instr_i   (scan_instr),
    .cf_o      (scan_cf),
    .imm_o     (scan_imm),
    .is_call_o (scan_call)
  );

  bht u_bht (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_i    (bht_idx),
    .rd_valid_o  (bht_valid),
    .rd_taken_o  (bht_taken),
    .upd_valid_i (bht_upd_valid),
    .upd_idx_i   (bht_upd_idx),
    .upd_taken_i (resolve_taken_i)
  );

  ras u_ras (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (ras_push),
    .pop_i       (ras_pop),
    .data_i      (ras_data),
    .top_o       (ras_top),
    .top_valid_o (ras_valid)
  );

  // the response word and its pc go straight into the queue
  fetch_queue u_queue (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (q_flush),
    .push_i              (q_push),
    .push_pc_i           (scan_pc),
    .push_instr_i        (scan_instr),
    .push_taken_i        (q_taken),
    .push_target_i       (q_target),
    .free_o              (q_free),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_pc_o          (fetch_pc_o),
    .fetch_instr_o       (fetch_instr_o),
    .fetch_pred_taken_o  (fetch_pred_taken_o),
    .fetch_pred_target_o (fetch_pred_target_o)
  );

endmodule

`default_nettype wire

//--- fetch_pkg.sv
// fetch frontend types
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

  // byte address and raw instruction word
  typedef logic [`FETCH_XLEN-1:0] addr_t;
  typedef logic [31:0] instr_t;

  // history index, word aligned so pc[1:0] is skipped
  typedef logic [$clog2(`FETCH_BHT_ENTRIES)-1:0] bht_idx_t;

  // fill level of the fetch queue, 0 up to full
  typedef logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] q_cnt_t;

  // control-flow kinds seen by the scanner
  typedef enum logic [2:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP,
    CF_JALR,
    CF_RETURN
  } cf_e;

  // pc bits 5 down to 2 select the history entry
  function automatic bht_idx_t bht_index(addr_t pc);
    return pc[$bits(bht_idx_t)+1:2];
  endfunction

endpackage

`default_nettype wire

//--- fetch_queue.sv
// fetch queue toward decode
`default_nettype none

`include "fetch_settings.svh"

module fetch_queue
  import fetch_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  // write side from pc_gen
  input  logic   push_i,
  input  addr_t  push_pc_i,
  input  instr_t push_instr_i,
  input  logic   push_taken_i,
  input  addr_t  push_target_i,
  output q_cnt_t free_o,
  // decode port
  output logic   fetch_valid_o,
  input  logic   fetch_ready_i,
  output addr_t  fetch_pc_o,
  output instr_t fetch_instr_o,
  output logic   fetch_pred_taken_o,
  output addr_t  fetch_pred_target_o
);

  localparam int unsigned Depth = `FETCH_QUEUE_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  q_cnt_t          count_q;
  logic            pop;

  addr_t  pc_q     [Depth];
  instr_t instr_q  [Depth];
  logic   taken_q  [Depth];
  addr_t  target_q [Depth];

  assign pop    = fetch_valid_o && fetch_ready_i;
  assign free_o = q_cnt_t'(Depth) - count_q;

  // head entry is always visible on the decode port
  assign fetch_valid_o       = (count_q != '0);
  assign fetch_pc_o          = pc_q[rd_ptr_q];
  assign fetch_instr_o       = instr_q[rd_ptr_q];
  assign fetch_pred_taken_o  = taken_q[rd_ptr_q];
  assign fetch_pred_target_o = target_q[rd_ptr_q];

  // payload write
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      pc_q[wr_ptr_q]     <= push_pc_i;
      instr_q[wr_ptr_q]  <= push_instr_i;
      taken_q[wr_ptr_q]  <= push_taken_i;
      target_q[wr_ptr_q] <= push_target_i;
    end
  end

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // flush drops everything, including a same-cycle push
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // request throttling in pc_gen must keep a slot for every response
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q != q_cnt_t'(Depth)))
    else $error("fetch queue push while full");

endmodule

`default_nettype wire

//--- fetch_settings.svh
// fetch frontend settings

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// --------------------
// widths and sizes
// --------------------
// address and data width
`define FETCH_XLEN 32
// 2-bit counter entries, indexed by pc[5:2]
`define FETCH_BHT_ENTRIES 16
`define FETCH_RAS_DEPTH 4
`define FETCH_QUEUE_DEPTH 4

// first fetch address out of reset
`define FETCH_BOOT_ADDR 32'h8000_0000

// --------------------
// rv32i opcodes
// --------------------
`define FETCH_OP_BRANCH 7'b1100011
`define FETCH_OP_JAL 7'b1101111
`define FETCH_OP_JALR 7'b1100111

`endif

//--- instr_scan.sv
// control-flow scanner
`default_nettype none

`include "fetch_settings.svh"

module instr_scan
  import fetch_pkg::*;
(
  input  instr_t instr_i,
  output cf_e    cf_o,
  output addr_t  imm_o,
  output logic   is_call_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;
  addr_t      imm_b;
  addr_t      imm_j;
  addr_t      imm_i;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // x1 and x5 are the link registers of the calling convention
  assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
  assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

  // --------------------
  // immediates
  // --------------------
  // all sign extended from bit 31
  assign imm_b = {{(`FETCH_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{(`FETCH_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_i = {{(`FETCH_XLEN-12){instr_i[31]}}, instr_i[31:20]};

  always_comb begin
    cf_o      = CF_NONE;
    imm_o     = imm_i;
    is_call_o = 1'b0;
    case (opcode)
      `FETCH_OP_BRANCH: begin
        cf_o  = CF_BRANCH;
        imm_o = imm_b;
      end
      `FETCH_OP_JAL: begin
        cf_o      = CF_JUMP;
        imm_o     = imm_j;
        is_call_o = rd_link;
      end
      `FETCH_OP_JALR: begin
        // jalr x0, 0(ra) is a return, anything else with a link rd is a call
        if ((rd == 5'd0) && rs1_link) begin
          cf_o = CF_RETURN;
        end else begin
          cf_o      = CF_JALR;
          is_call_o = rd_link;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- pc_gen.sv
// next pc and fetch request control
`default_nettype none

`include "fetch_settings.svh"

module pc_gen
  import fetch_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // instruction memory port
  output logic     imem_req_o,
  output addr_t    imem_addr_o,
  input  logic     imem_gnt_i,
  input  logic     imem_rvalid_i,
  input  instr_t   imem_rdata_i,
  // redirects from the backend
  input  logic     trap_i,
  input  addr_t    trap_vector_i,
  input  logic     resolve_valid_i,
  input  logic     resolve_mispredict_i,
  input  addr_t    resolve_target_i,
  // scanner
  output addr_t    scan_pc_o,
  output instr_t   scan_instr_o,
  input  cf_e      scan_cf_i,
  input  addr_t    scan_imm_i,
  input  logic     scan_call_i,
  // predictors
  output bht_idx_t bht_idx_o,
  input  logic     bht_valid_i,
  input  logic     bht_taken_i,
  output logic     ras_push_o,
  output logic     ras_pop_o,
  output addr_t    ras_data_o,
  input  addr_t    ras_top_i,
  input  logic     ras_valid_i,
  // fetch queue
  output logic     q_push_o,
  output logic     q_taken_o,
  output addr_t    q_target_o,
  output logic     q_flush_o,
  input  q_cnt_t   q_free_i
);

  addr_t pc_q;
  addr_t pc_d;
  addr_t pc_plus4;
  logic  outstanding_q;
  logic  stale_q;
  logic  run_q;
  logic  redirect;
  logic  accept;
  logic  slot_ok;
  logic  taken;
  addr_t target;

  // pc_q is the pc of the response, a request in the response cycle goes to the next pc
  assign imem_addr_o  = accept ? target : pc_q;
  assign scan_pc_o    = pc_q;
  assign scan_instr_o = imem_rdata_i;
  assign bht_idx_o    = bht_index(pc_q);
  assign pc_plus4     = pc_q + addr_t'(4);

  assign redirect  = trap_i || (resolve_valid_i && resolve_mispredict_i);
  assign q_flush_o = redirect;

  // a response for a pc fetched before a redirect is dropped
  assign accept = imem_rvalid_i && !stale_q && !redirect;

  // keep a slot free for the response that lands this cycle
  assign slot_ok = (q_free_i != '0) && !(q_push_o && (q_free_i == q_cnt_t'(1)));

  // new request once the bus is idle or closing, never on a redirect edge
  assign imem_req_o = run_q && (!outstanding_q || imem_rvalid_i) && slot_ok && !redirect;

  // --------------------
  // prediction
  // --------------------
  always_comb begin
    taken  = 1'b0;
    target = pc_plus4;
    case (scan_cf_i)
      // static fallback: backward branches are taken
      CF_BRANCH: taken = bht_valid_i ? bht_taken_i : scan_imm_i[`FETCH_XLEN-1];
      CF_JUMP:   taken = 1'b1;
      CF_RETURN: taken = ras_valid_i;
      // plain jalr has no target source, left to the backend
      default:   taken = 1'b0;
    endcase
    if (taken) begin
      target = (scan_cf_i == CF_RETURN) ? ras_top_i : pc_q + scan_imm_i;
    end
  end

  assign q_push_o   = accept;
  assign q_taken_o  = taken;
  assign q_target_o = target;
  assign ras_push_o = accept && scan_call_i;
  assign ras_pop_o  = accept && (scan_cf_i == CF_RETURN) && ras_valid_i;
  assign ras_data_o = pc_plus4;

  // trap, then mispredict, then prediction or pc+4
  always_comb begin
    if (trap_i) begin
      pc_d = trap_vector_i;
    end else if (resolve_valid_i && resolve_mispredict_i) begin
      pc_d = resolve_target_i;
    end else if (accept) begin
      pc_d = target;
    end else begin
      pc_d = pc_q;
    end
  end

  // --------------------
  // state
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q          <= `FETCH_BOOT_ADDR;
      outstanding_q <= 1'b0;
      stale_q       <= 1'b0;
      run_q         <= 1'b0;
    end else begin
      pc_q  <= pc_d;
      run_q <= 1'b1;
      if (imem_req_o && imem_gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (imem_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
      if (imem_rvalid_i) begin
        stale_q <= 1'b0;
      end else if (redirect && outstanding_q) begin
        stale_q <= 1'b1;
      end
    end
  end

  a_rvalid_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_rvalid_i |-> outstanding_q)
    else $error("imem response without outstanding request");

endmodule

`default_nettype wire

//--- ras.sv
// return address stack
`default_nettype none

`include "fetch_settings.svh"

module ras
  import fetch_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  logic  pop_i,
  input  addr_t data_i,
  output addr_t top_o,
  output logic  top_valid_o
);

  localparam int unsigned Depth = `FETCH_RAS_DEPTH;

  // entry 0 is the top, the oldest falls off the far end
  addr_t stack_q [Depth];
  logic  valid_q [Depth];

  assign top_o       = stack_q[0];
  assign top_valid_o = valid_q[0];

  // --------------------
  // stack payload
  // --------------------
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      stack_q[0] <= data_i;
      // push with pop just replaces the top
      if (!pop_i) begin
        for (int i = 1; i < Depth; i++) begin
          stack_q[i] <= stack_q[i-1];
        end
      end
    end else if (pop_i) begin
      for (int i = 0; i < Depth - 1; i++) begin
        stack_q[i] <= stack_q[i+1];
      end
    end
  end

  // valid bits move along with the payload
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (push_i) begin
      valid_q[0] <= 1'b1;
      if (!pop_i) begin
        for (int i = 1; i < Depth; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end else if (pop_i) begin
      for (int i = 0; i < Depth - 1; i++) begin
        valid_q[i] <= valid_q[i+1];
      end
      valid_q[Depth-1] <= 1'b0;
    end
  end

  // pc_gen only pops when it saw a valid top
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> top_valid_o)
    else $error("ras popped while empty");

endmodule

`default_nettype wire

//--- src.f
+incdir+.
fetch_pkg.sv
instr_scan.sv
bht.sv
ras.sv
fetch_queue.sv
pc_gen.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- tb_fetch_frontend.sv
// fetch frontend testbench
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch_frontend
  import fetch_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam addr_t       BootAddr      = `FETCH_BOOT_ADDR;
  localparam int unsigned EntriesPerTest = 50;
  // six tests of roughly 200 to 450 cycles each, doubled for headroom
  localparam int unsigned TimeoutCycles = 4000;

  typedef struct packed {
    addr_t  pc;
    instr_t instr;
    logic   taken;
    addr_t  target;
  } exp_entry_t;

  logic   clk_i;
  logic   rst_ni;
  logic   imem_req_o;
  addr_t  imem_addr_o;
  logic   imem_gnt_i;
  logic   imem_rvalid_i;
  instr_t imem_rdata_i;
  logic   resolve_valid_i;
  addr_t  resolve_pc_i;
  logic   resolve_branch_i;
  logic   resolve_taken_i;
  logic   resolve_mispredict_i;
  addr_t  resolve_target_i;
  logic   trap_i;
  addr_t  trap_vector_i;
  logic   fetch_valid_o;
  logic   fetch_ready_i;
  addr_t  fetch_pc_o;
  instr_t fetch_instr_o;
  logic   fetch_pred_taken_o;
  addr_t  fetch_pred_target_o;

  // memory model state
  instr_t      mem [addr_t];
  logic        pending = 1'b0;
  addr_t       pend_addr;
  int unsigned resp_wait = 0;

  // reference predictor state
  addr_t       m_pc = `FETCH_BOOT_ADDR;
  logic        stale = 1'b0;
  logic        bht_ok  [`FETCH_BHT_ENTRIES];
  logic [1:0]  bht_cnt [`FETCH_BHT_ENTRIES];
  addr_t       ras_m [$];
  exp_entry_t  exp_q [$];
  addr_t       br_pcs [$];

  // test knobs and counters
  string       test_name = "reset";
  int unsigned mix;
  logic        train_mode;
  logic        redir_mode;
  logic        stall_mode;
  addr_t       region_base;
  int unsigned test_cycle;
  int unsigned test_checked;
  int unsigned test_errors;
  int unsigned total_checked = 0;
  int unsigned total_errors = 0;
  int unsigned tests_run = 0;
  int unsigned cycle_cnt = 0;

  fetch_frontend u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------
  // program generation
  // --------------------
  function automatic addr_t rand_offset(int unsigned max_words);
    addr_t off;
    off = addr_t'(4 * $urandom_range(max_words, 1));
    if ($urandom_range(1, 0) == 1) begin
      off = -off;
    end
    return off;
  endfunction

  function automatic instr_t gen_word();
    int unsigned r;
    int unsigned kind;
    addr_t       off;
    logic [4:0]  ra;
    r    = $urandom_range(15, 0);
    ra   = ($urandom_range(1, 0) == 1) ? 5'd1 : 5'd5;
    off  = rand_offset(24);
    // 0 alu, 1 branch, 2 jal x0, 3 jal call, 4 jalr call, 5 return, 6 plain jalr
    kind = 0;
    if (r >= 8) begin
      case (mix)
        1: kind = (r < 12) ? 1 : 2;
        2: kind = 1;
        3: kind = (r < 10) ? 3 : (r < 11) ? 4 : (r < 14) ? 5 : 6;
        4: kind = (r < 10) ? 1 : (r < 11) ? 2 : (r < 12) ? 3 : (r < 13) ? 4 : (r < 14) ? 5 : 6;
        default: kind = 0;
      endcase
    end
    case (kind)
      1: return {off[12], off[10:5], 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                 3'b000, off[4:1], off[11], `FETCH_OP_BRANCH};
      2: return {off[20], off[10:1], off[11], off[19:12], 5'd0, `FETCH_OP_JAL};
      3: return {off[20], off[10:1], off[11], off[19:12], ra, `FETCH_OP_JAL};
      4: return {12'h000, 5'd6, 3'b000, ra, `FETCH_OP_JALR};
      5: return {12'h000, ra, 3'b000, 5'd0, `FETCH_OP_JALR};
      6: return {12'h000, 5'd7, 3'b000, 5'd3, `FETCH_OP_JALR};
      // addi with random operands
      default: return {12'($urandom_range(4095, 0)), 5'($urandom_range(31, 0)), 3'b000,
                       5'($urandom_range(31, 1)), 7'b0010011};
    endcase
  endfunction

  // words appear on first access
  function automatic instr_t mem_word(addr_t a);
    if (!mem.exists(a)) begin
      mem[a] = gen_word();
    end
    return mem[a];
  endfunction

  // --------------------
  // reference model
  // --------------------
  function automatic logic is_link(logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  task automatic train_model(logic [3:0] idx, logic tk);
    if (!bht_ok[idx]) begin
      bht_ok[idx]  = 1'b1;
      bht_cnt[idx] = tk ? 2'd2 : 2'd1;
    end else if (tk && (bht_cnt[idx] != 2'd3)) begin
      bht_cnt[idx] = bht_cnt[idx] + 2'd1;
    end else if (!tk && (bht_cnt[idx] != 2'd0)) begin
      bht_cnt[idx] = bht_cnt[idx] - 2'd1;
    end
  endtask

  // predicted entry for the word at m_pc, then step m_pc
  task automatic model_response();
    instr_t     w;
    addr_t      imm;
    logic       tk;
    logic       call;
    logic [3:0] idx;
    exp_entry_t ent;
    w    = mem_word(m_pc);
    idx  = m_pc[5:2];
    tk   = 1'b0;
    call = 1'b0;
    ent.target = m_pc + 32'd4;
    if (w[6:0] == `FETCH_OP_BRANCH) begin
      imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      tk  = bht_ok[idx] ? bht_cnt[idx][1] : imm[31];
      if (tk) begin
        ent.target = m_pc + imm;
      end
      br_pcs.push_back(m_pc);
      if (br_pcs.size() > 8) begin
        void'(br_pcs.pop_front());
      end
    end else if (w[6:0] == `FETCH_OP_JAL) begin
      imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      tk   = 1'b1;
      call = is_link(w[11:7]);
      ent.target = m_pc + imm;
    end else if (w[6:0] == `FETCH_OP_JALR) begin
      if ((w[11:7] == 5'd0) && is_link(w[19:15])) begin
        // return, empty stack falls through
        if (ras_m.size() > 0) begin
          tk = 1'b1;
          ent.target = ras_m.pop_front();
        end
      end else begin
        call = is_link(w[11:7]);
      end
    end
    if (call) begin
      ras_m.push_front(m_pc + 32'd4);
      if (ras_m.size() > `FETCH_RAS_DEPTH) begin
        void'(ras_m.pop_back());
      end
    end
    ent.pc    = m_pc;
    ent.instr = w;
    ent.taken = tk;
    exp_q.push_back(ent);
    m_pc = ent.target;
  endtask

  task automatic check_field(string what, addr_t exp, addr_t act);
    assert (exp === act) else begin
      $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
  end

  always @(posedge clk_i) begin : monitor
    exp_entry_t head;
    logic       redirect;
    if (rst_ni) begin
      redirect = trap_i || (resolve_valid_i && resolve_mispredict_i);
      // decode handshake against the expected head
      if (fetch_valid_o && fetch_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Error: %s delivered an entry that was not expected", test_name);
          test_errors++;
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          check_field("pc", head.pc, fetch_pc_o);
          check_field("instr", head.instr, fetch_instr_o);
          check_field("pred_taken", addr_t'(head.taken), addr_t'(fetch_pred_taken_o));
          check_field("pred_target", head.target, fetch_pred_target_o);
          test_checked++;
        end
      end
      // response closes the outstanding request
      if (imem_rvalid_i) begin
        if (!stale && !redirect) begin
          model_response();
        end
        pending = 1'b0;
        stale   = 1'b0;
      end else if (redirect && pending) begin
        stale = 1'b1;
      end
      // trap wins over mispredict
      if (redirect) begin
        exp_q.delete();
        m_pc = trap_i ? trap_vector_i : resolve_target_i;
      end
      if (imem_req_o && imem_gnt_i) begin
        check_field("fetch address", m_pc, imem_addr_o);
        pending   = 1'b1;
        pend_addr = imem_addr_o;
        resp_wait = $urandom_range(4, 1);
      end
      // history update is seen from the next cycle on
      if (resolve_valid_i && resolve_branch_i) begin
        train_model(resolve_pc_i[5:2], resolve_taken_i);
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic drive_cycle();
    int unsigned r;
    imem_rvalid_i = 1'b0;
    if (pending && (resp_wait > 0)) begin
      resp_wait--;
      if (resp_wait == 0) begin
        imem_rvalid_i = 1'b1;
        imem_rdata_i  = mem_word(pend_addr);
      end
    end
    // a grant may also land in the response cycle
    imem_gnt_i = ($urandom_range(3, 0) != 0);
    if (stall_mode) begin
      fetch_ready_i = ((test_cycle % 64) >= 48) && ($urandom_range(3, 0) != 0);
    end else begin
      fetch_ready_i = ($urandom_range(3, 0) != 0);
    end
    resolve_valid_i      = 1'b0;
    resolve_branch_i     = 1'b0;
    resolve_taken_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    trap_i               = 1'b0;
    r = $urandom_range(63, 0);
    if (redir_mode && (r < 3)) begin
      if (r < 2) begin
        resolve_valid_i      = 1'b1;
        resolve_mispredict_i = 1'b1;
        resolve_target_i     = region_base + addr_t'(4 * $urandom_range(63, 0));
      end
      if (r != 1) begin
        trap_i        = 1'b1;
        trap_vector_i = region_base + 32'h800 + addr_t'(4 * $urandom_range(15, 0));
      end
      // decode holds off while the queue flushes
      fetch_ready_i = 1'b0;
    end else if (train_mode && (br_pcs.size() > 0) && ($urandom_range(2, 0) == 0)) begin
      resolve_valid_i  = 1'b1;
      resolve_branch_i = 1'b1;
      resolve_pc_i     = br_pcs[$urandom_range(br_pcs.size() - 1, 0)];
      // direction biased by pc bit 6, not by offset sign
      resolve_taken_i  = resolve_pc_i[6] ? ($urandom_range(3, 0) != 0)
                                         : ($urandom_range(3, 0) == 0);
    end
    test_cycle++;
  endtask

  task automatic run_test(string name, int unsigned mix_sel, logic train, logic redir,
                          logic stall, int unsigned region);
    test_name    = name;
    mix          = mix_sel;
    train_mode   = train;
    redir_mode   = redir;
    stall_mode   = stall;
    region_base  = BootAddr + addr_t'(region << 16);
    test_cycle   = 0;
    test_checked = 0;
    test_errors  = 0;
    // a trap moves fetch into a fresh code region
    if (region != 0) begin
      @(negedge clk_i);
      drive_cycle();
      resolve_valid_i = 1'b0;
      trap_i          = 1'b1;
      trap_vector_i   = region_base;
      fetch_ready_i   = 1'b0;
    end
    while (test_checked < EntriesPerTest) begin
      @(negedge clk_i);
      drive_cycle();
    end
    $display("%s: %0d entries checked, %0d errors", name, test_checked, test_errors);
    total_checked += test_checked;
    total_errors  += test_errors;
    tests_run++;
  endtask

  initial begin : watchdog
    wait (cycle_cnt >= TimeoutCycles);
    $display("Error: run timed out after %0d cycles in %s", cycle_cnt, test_name);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    void'($urandom(32'had75_cdd4));
    rst_ni               = 1'b0;
    imem_gnt_i           = 1'b0;
    imem_rvalid_i        = 1'b0;
    imem_rdata_i         = '0;
    resolve_valid_i      = 1'b0;
    resolve_pc_i         = '0;
    resolve_branch_i     = 1'b0;
    resolve_taken_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_target_i     = '0;
    trap_i               = 1'b0;
    trap_vector_i        = '0;
    fetch_ready_i        = 1'b0;
    for (int i = 0; i < `FETCH_BHT_ENTRIES; i++) begin
      bht_ok[i]  = 1'b0;
      bht_cnt[i] = 2'd0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    // no request and no decode entry while reset is held
    test_errors = 0;
    check_field("imem_req_o", '0, addr_t'(imem_req_o));
    check_field("fetch_valid_o", '0, addr_t'(fetch_valid_o));
    $display("%s: %0d errors", test_name, test_errors);
    total_errors += test_errors;
    tests_run++;
    rst_ni = 1'b1;

    run_test("sequential_boot", 0, 1'b0, 1'b0, 1'b0, 0);
    run_test("jal_static_branch", 1, 1'b0, 1'b0, 1'b0, 1);
    run_test("trained_branch", 2, 1'b1, 1'b0, 1'b0, 2);
    run_test("call_return", 3, 1'b0, 1'b0, 1'b0, 3);
    run_test("redirects", 4, 1'b1, 1'b1, 1'b0, 4);
    run_test("back_pressure", 4, 1'b0, 1'b0, 1'b1, 5);

    $display("tests %0d, entries checked %0d, errors %0d", tests_run, total_checked,
             total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
